// ==== design/ooo_defs.svh ====
// Sizing macros for the reservation station cluster
// Entry count, tag and data widths, buffer depths
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

`default_nettype none

// Number of reservation station entries
`define RS_SIZE 4

// Producer and destination tag width
`define TAG_BITS 5

// Data path width
`define XLEN 32

// Dispatch buffer depth, also the front end's starting credit count
`define DISPATCH_DEPTH 4

// Result buffer depth, also the scheduler's starting credit count
`define RESULT_DEPTH 4

`default_nettype wire

`endif

// ==== design/ooo_inst_pkg.sv ====
// Instruction side types
// ALU operation codes, operands and the dispatch packet
`include "ooo_defs.svh"

`default_nettype none

package ooo_inst_pkg;

    // Integer ALU operations
    // Shifts take the low 5 bits of operand b, slt compares signed
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_sll = 3'd5,
        op_srl = 3'd6,
        op_slt = 3'd7
    } alu_op_e;

    // Value when valid, otherwise the producer tag sits in the low bits
    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  value;
    } operand_t;

    // One decoded operation from the front end
    typedef struct packed {
        alu_op_e               op;
        logic [`TAG_BITS-1:0]  dest_tag;
        operand_t              a;
        operand_t              b;
    } dispatch_t;

endpackage

`default_nettype wire

// ==== design/ooo_bus_pkg.sv ====
// Bus side types
// ALU issue packet and CDB broadcast
`include "ooo_defs.svh"

`default_nettype none

package ooo_bus_pkg;

    // Ready operation sent from the scheduler to the ALU
    typedef struct packed {
        ooo_inst_pkg::alu_op_e  op;
        logic [`TAG_BITS-1:0]   dest_tag;
        logic [`XLEN-1:0]       a_value;
        logic [`XLEN-1:0]       b_value;
    } issue_t;

    // One broadcast on the common data bus
    typedef struct packed {
        logic                  valid;
        logic [`TAG_BITS-1:0]  tag;
        logic [`XLEN-1:0]      value;
    } cdb_t;

endpackage

`default_nettype wire

// ==== design/payload_fifo.sv ====
// Circular buffer with a type parameter for its payload
`timescale 1ns/1ps

`default_nettype none

module payload_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic push,
    input  payload_t  push_data,
    input  wire logic pop,
    output payload_t  head,
    output logic      not_empty
);

    localparam int PTR_BITS   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_BITS = $clog2(DEPTH + 1);

    payload_t              mem [DEPTH];
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [COUNT_BITS-1:0] count;

    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Credit holders upstream keep these from ever firing
    a_no_overflow: assert property (@(posedge clock) disable iff (reset)
        push |-> (count != COUNT_BITS'(DEPTH)));
    a_no_underflow: assert property (@(posedge clock) disable iff (reset)
        pop |-> not_empty);

endmodule

`default_nettype wire

// ==== design/rs_entry.sv ====
// Single reservation station entry
// Holds one operation and captures pending operands from the CDB
`timescale 1ns/1ps
`include "ooo_defs.svh"

`default_nettype none

module rs_entry (
    input  wire logic                clock,
    input  wire logic                reset,
    input  wire logic                load,
    input  ooo_inst_pkg::dispatch_t  load_data,
    input  wire logic                free,
    input  ooo_bus_pkg::cdb_t        cdb,
    output logic                     busy,
    output logic                     ready,
    output ooo_bus_pkg::issue_t      entry_data
);

    ooo_inst_pkg::alu_op_e  op;
    logic [`TAG_BITS-1:0]   dest_tag;
    logic                   a_valid;
    logic                   b_valid;
    // Operand value, or producer tag in the low bits while pending
    logic [`XLEN-1:0]       a_field;
    logic [`XLEN-1:0]       b_field;

    logic a_hit_load;
    logic b_hit_load;
    logic a_hit_wait;
    logic b_hit_wait;

    ////////////////////////////////////////////////////////////////////////////
    // Tag match against the CDB, for incoming and held operands
    ////////////////////////////////////////////////////////////////////////////
    assign a_hit_load = cdb.valid && !load_data.a.valid &&
                        (cdb.tag == load_data.a.value[`TAG_BITS-1:0]);
    assign b_hit_load = cdb.valid && !load_data.b.valid &&
                        (cdb.tag == load_data.b.value[`TAG_BITS-1:0]);
    assign a_hit_wait = cdb.valid && busy && !a_valid && (cdb.tag == a_field[`TAG_BITS-1:0]);
    assign b_hit_wait = cdb.valid && busy && !b_valid && (cdb.tag == b_field[`TAG_BITS-1:0]);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy    <= 1'b0;
            a_valid <= 1'b0;
            b_valid <= 1'b0;
        end else if (load) begin
            busy    <= 1'b1;
            a_valid <= load_data.a.valid || a_hit_load;
            b_valid <= load_data.b.valid || b_hit_load;
        end else begin
            if (free) begin
                busy <= 1'b0;
            end
            if (a_hit_wait) begin
                a_valid <= 1'b1;
            end
            if (b_hit_wait) begin
                b_valid <= 1'b1;
            end
        end
    end

    // Operation and operand payload
    always_ff @(posedge clock) begin
        if (load) begin
            op       <= load_data.op;
            dest_tag <= load_data.dest_tag;
            a_field  <= a_hit_load ? cdb.value : load_data.a.value;
            b_field  <= b_hit_load ? cdb.value : load_data.b.value;
        end else begin
            if (a_hit_wait) begin
                a_field <= cdb.value;
            end
            if (b_hit_wait) begin
                b_field <= cdb.value;
            end
        end
    end

    assign ready      = busy && a_valid && b_valid;
    assign entry_data = '{op: op, dest_tag: dest_tag, a_value: a_field, b_value: b_field};

    // Scheduler only allocates entries that are free
    a_load_when_free: assert property (@(posedge clock) disable iff (reset)
        load |-> !busy);

endmodule

`default_nettype wire

// ==== design/rs_scheduler.sv ====
// Reservation station scheduler
// Free entry allocation, ready entry issue, result credit counter
`timescale 1ns/1ps
`include "ooo_defs.svh"

`default_nettype none

module rs_scheduler (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 fifo_not_empty,
    output logic                      fifo_pop,
    input  wire logic [`RS_SIZE-1:0]  entry_busy,
    input  wire logic [`RS_SIZE-1:0]  entry_ready,
    output logic [`RS_SIZE-1:0]       entry_load,
    output logic [`RS_SIZE-1:0]       entry_free,
    input  ooo_bus_pkg::issue_t       entry_data [`RS_SIZE],
    output logic                      issue_valid,
    output ooo_bus_pkg::issue_t       issue_data,
    input  wire logic                 result_pop
);

    localparam int IDX_BITS    = (`RS_SIZE > 1) ? $clog2(`RS_SIZE) : 1;
    localparam int CREDIT_BITS = $clog2(`RESULT_DEPTH + 1);

    logic [IDX_BITS-1:0]    alloc_idx;
    logic [IDX_BITS-1:0]    issue_idx;
    logic [CREDIT_BITS-1:0] credits;
    logic                   have_credit;

    // Priority encoder, lowest set bit wins
    function automatic logic [IDX_BITS-1:0] lowest_index(input logic [`RS_SIZE-1:0] vec);
        logic [IDX_BITS-1:0] idx;
        idx = '0;
        for (int i = `RS_SIZE - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = IDX_BITS'(i);
            end
        end
        return idx;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Allocation
    ////////////////////////////////////////////////////////////////////////////
    assign alloc_idx  = lowest_index(~entry_busy);
    assign fifo_pop   = fifo_not_empty && !(&entry_busy);
    assign entry_load = fifo_pop ? (`RS_SIZE'(1) << alloc_idx) : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Issue
    ////////////////////////////////////////////////////////////////////////////
    assign have_credit = (credits != '0);
    assign issue_idx   = lowest_index(entry_ready);
    assign issue_valid = have_credit && (|entry_ready);
    assign issue_data  = entry_data[issue_idx];
    assign entry_free  = issue_valid ? (`RS_SIZE'(1) << issue_idx) : '0;

    // One credit per free result buffer slot
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            credits <= CREDIT_BITS'(`RESULT_DEPTH);
        end else begin
            case ({result_pop, issue_valid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    a_credit_bound: assert property (@(posedge clock) disable iff (reset)
        credits <= CREDIT_BITS'(`RESULT_DEPTH));
    // An issue at zero credits would wrap the counter upward
    a_issue_needs_credit: assert property (@(posedge clock) disable iff (reset)
        issue_valid && !result_pop |=> credits < $past(credits));

endmodule

`default_nettype wire

// ==== design/alu_pipe.sv ====
// Two-stage integer ALU with tagged results
`timescale 1ns/1ps
`include "ooo_defs.svh"

`default_nettype none

module alu_pipe (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire logic            issue_valid,
    input  ooo_bus_pkg::issue_t  issue_data,
    output ooo_bus_pkg::cdb_t    result
);

    logic                  s1_valid;
    ooo_bus_pkg::issue_t   s1_data;
    logic [`XLEN-1:0]      alu_value;
    logic                  res_valid;
    logic [`TAG_BITS-1:0]  res_tag;
    logic [`XLEN-1:0]      res_value;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            s1_valid  <= issue_valid;
            res_valid <= s1_valid;
        end
    end

    // Stage one operand register
    always_ff @(posedge clock) begin
        s1_data <= issue_data;
    end

    always_comb begin
        case (s1_data.op)
            ooo_inst_pkg::op_add: alu_value = s1_data.a_value + s1_data.b_value;
            ooo_inst_pkg::op_sub: alu_value = s1_data.a_value - s1_data.b_value;
            ooo_inst_pkg::op_and: alu_value = s1_data.a_value & s1_data.b_value;
            ooo_inst_pkg::op_or:  alu_value = s1_data.a_value | s1_data.b_value;
            ooo_inst_pkg::op_xor: alu_value = s1_data.a_value ^ s1_data.b_value;
            ooo_inst_pkg::op_sll: alu_value = s1_data.a_value << s1_data.b_value[4:0];
            ooo_inst_pkg::op_srl: alu_value = s1_data.a_value >> s1_data.b_value[4:0];
            default: alu_value = `XLEN'($signed(s1_data.a_value) < $signed(s1_data.b_value));
        endcase
    end

    // Stage two result register
    always_ff @(posedge clock) begin
        res_tag   <= s1_data.dest_tag;
        res_value <= alu_value;
    end

    assign result = '{valid: res_valid, tag: res_tag, value: res_value};

endmodule

`default_nettype wire

// ==== design/rs_cluster_top.sv ====
// Issue cluster top level
// Dispatch buffer, reservation entries, scheduler, ALU and result buffer
`timescale 1ns/1ps
`include "ooo_defs.svh"

`default_nettype none

module rs_cluster_top (
    input  wire logic                clock,
    input  wire logic                reset,
    input  wire logic                dispatch_valid,
    input  ooo_inst_pkg::dispatch_t  dispatch_data,
    output logic                     dispatch_credit,
    output ooo_bus_pkg::cdb_t        cdb
);

    ooo_inst_pkg::dispatch_t  disp_head;
    logic                     disp_not_empty;
    logic                     disp_pop;
    logic [`RS_SIZE-1:0]      entry_busy;
    logic [`RS_SIZE-1:0]      entry_ready;
    logic [`RS_SIZE-1:0]      entry_load;
    logic [`RS_SIZE-1:0]      entry_free;
    ooo_bus_pkg::issue_t      entry_data [`RS_SIZE];
    logic                     issue_valid;
    ooo_bus_pkg::issue_t      issue_data;
    ooo_bus_pkg::cdb_t        alu_result;
    ooo_bus_pkg::cdb_t        res_head;
    logic                     res_not_empty;

    // Each pop hands one credit back to the front end
    assign dispatch_credit = disp_pop;

    payload_fifo #(.payload_t(ooo_inst_pkg::dispatch_t), .DEPTH(`DISPATCH_DEPTH)) dispatch_fifo_i (
        .clock(clock), .reset(reset),
        .push(dispatch_valid), .push_data(dispatch_data),
        .pop(disp_pop), .head(disp_head), .not_empty(disp_not_empty)
    );

    for (genvar i = 0; i < `RS_SIZE; i++) begin : g_entry
        rs_entry rs_entry_i (
            .clock(clock), .reset(reset),
            .load(entry_load[i]), .load_data(disp_head),
            .free(entry_free[i]), .cdb(cdb),
            .busy(entry_busy[i]), .ready(entry_ready[i]), .entry_data(entry_data[i])
        );
    end

    rs_scheduler rs_scheduler_i (
        .clock(clock), .reset(reset),
        .fifo_not_empty(disp_not_empty), .fifo_pop(disp_pop),
        .entry_busy(entry_busy), .entry_ready(entry_ready),
        .entry_load(entry_load), .entry_free(entry_free), .entry_data(entry_data),
        .issue_valid(issue_valid), .issue_data(issue_data), .result_pop(cdb.valid)
    );

    alu_pipe alu_pipe_i (
        .clock(clock), .reset(reset),
        .issue_valid(issue_valid), .issue_data(issue_data), .result(alu_result)
    );

    payload_fifo #(.payload_t(ooo_bus_pkg::cdb_t), .DEPTH(`RESULT_DEPTH)) result_fifo_i (
        .clock(clock), .reset(reset),
        .push(alu_result.valid), .push_data(alu_result),
        .pop(cdb.valid), .head(res_head), .not_empty(res_not_empty)
    );

    // Buffer head is the broadcast, popped at the end of the cycle
    assign cdb = '{valid: res_not_empty, tag: res_head.tag, value: res_head.value};

endmodule

`default_nettype wire

// ==== dv/rs_cluster_tb.sv ====
// Testbench for the reservation station cluster
// Random dispatch with a tag table model that checks every CDB broadcast
`timescale 1ns/1ps
`include "ooo_defs.svh"

`default_nettype none

module rs_cluster_tb;

    localparam int CLK_PERIOD     = 10;
    localparam int NUM_TAGS       = 1 << `TAG_BITS;
    localparam int CREDIT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 1000;

    logic                     clock;
    logic                     reset;
    logic                     dispatch_valid;
    ooo_inst_pkg::dispatch_t  dispatch_data;
    logic                     dispatch_credit;
    ooo_bus_pkg::cdb_t        cdb;

    // Front end credits and run status
    int  credits;
    int  errors;
    int  broadcasts;
    int  tests_passed;
    int  tests_failed;
    int  test_num;
    int  test_start_errors;
    bit  timed_out;

    // Tag table, one slot per tag in flight
    bit                     in_flight [NUM_TAGS];
    int                     in_flight_count;
    ooo_inst_pkg::alu_op_e  m_op [NUM_TAGS];
    bit                     a_pend [NUM_TAGS];
    bit                     b_pend [NUM_TAGS];
    logic [`XLEN-1:0]       a_val [NUM_TAGS];
    logic [`XLEN-1:0]       b_val [NUM_TAGS];

    // Last dispatch, for back-to-back dependent operations
    int   prev_tag;
    bit   have_prev;
    time  last_dispatch_time;

    rs_cluster_top dut_i (
        .clock(clock),
        .reset(reset),
        .dispatch_valid(dispatch_valid),
        .dispatch_data(dispatch_data),
        .dispatch_credit(dispatch_credit),
        .cdb(cdb)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clock = ~clock;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [`XLEN-1:0] alu_model(input ooo_inst_pkg::alu_op_e op,
                                                    input logic [`XLEN-1:0] a,
                                                    input logic [`XLEN-1:0] b);
        case (op)
            ooo_inst_pkg::op_add: return a + b;
            ooo_inst_pkg::op_sub: return a - b;
            ooo_inst_pkg::op_and: return a & b;
            ooo_inst_pkg::op_or:  return a | b;
            ooo_inst_pkg::op_xor: return a ^ b;
            ooo_inst_pkg::op_sll: return a << b[4:0];
            ooo_inst_pkg::op_srl: return a >> b[4:0];
            default:              return ($signed(a) < $signed(b)) ? `XLEN'(1) : `XLEN'(0);
        endcase
    endfunction

    function automatic int pick_free_tag();
        int start;
        int t;
        start = $urandom_range(NUM_TAGS - 1);
        for (int k = 0; k < NUM_TAGS; k++) begin
            t = (start + k) % NUM_TAGS;
            if (!in_flight[t]) begin
                return t;
            end
        end
        return 0;
    endfunction

    function automatic ooo_inst_pkg::operand_t make_operand(input bit pending, input int src);
        ooo_inst_pkg::operand_t opnd;
        opnd.valid = !pending;
        opnd.value = pending ? `XLEN'(src) : `XLEN'($urandom());
        return opnd;
    endfunction

    // Holds a tag for a producer that is dispatched later
    task automatic reserve_tag(input int tag);
        in_flight[tag] = 1'b1;
        a_pend[tag]    = 1'b0;
        b_pend[tag]    = 1'b0;
        in_flight_count++;
    endtask

    task automatic record_op(input int tag, input ooo_inst_pkg::dispatch_t pkt);
        if (!in_flight[tag]) begin
            in_flight_count++;
        end
        in_flight[tag] = 1'b1;
        m_op[tag]      = pkt.op;
        a_pend[tag]    = !pkt.a.valid;
        b_pend[tag]    = !pkt.b.valid;
        a_val[tag]     = pkt.a.value;
        b_val[tag]     = pkt.b.value;
    endtask

    task automatic check_broadcast(input int tag, input logic [`XLEN-1:0] value);
        logic [`XLEN-1:0] expected;
        broadcasts++;
        if (!in_flight[tag]) begin
            $display("CHECK FAILED at %0t: tag %0d broadcast while not in flight", $time, tag);
            errors++;
        end else begin
            if (a_pend[tag] || b_pend[tag]) begin
                $display("CHECK FAILED at %0t: tag %0d broadcast before its sources", $time, tag);
                errors++;
            end else begin
                expected = alu_model(m_op[tag], a_val[tag], b_val[tag]);
                if (value !== expected) begin
                    $display("CHECK FAILED at %0t: tag %0d value %h, expected %h",
                             $time, tag, value, expected);
                    errors++;
                end
            end
            // Wake up consumers waiting on this tag
            for (int t = 0; t < NUM_TAGS; t++) begin
                if (in_flight[t] && t != tag) begin
                    if (a_pend[t] && a_val[t][`TAG_BITS-1:0] == tag) begin
                        a_pend[t] = 1'b0;
                        a_val[t]  = value;
                    end
                    if (b_pend[t] && b_val[t][`TAG_BITS-1:0] == tag) begin
                        b_pend[t] = 1'b0;
                        b_val[t]  = value;
                    end
                end
            end
            in_flight[tag] = 1'b0;
            in_flight_count--;
        end
    endtask

    // Outputs are sampled mid-cycle, away from the clock edge
    always @(negedge clock) begin
        if (!reset) begin
            if (dispatch_credit) begin
                credits++;
                if (credits > `DISPATCH_DEPTH) begin
                    $display("CHECK FAILED at %0t: credit returned with none outstanding",
                             $time);
                    errors++;
                end
            end
            if (cdb.valid) begin
                check_broadcast(cdb.tag, cdb.value);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Front end driver
    ////////////////////////////////////////////////////////////////////////////
    task automatic wait_for_credit(output bit no_wait);
        int cycles;
        cycles = 0;
        while (!timed_out && credits == 0) begin
            if (cycles == CREDIT_TIMEOUT) begin
                $display("Timed out waiting for a dispatch credit");
                timed_out = 1'b1;
            end else begin
                @(posedge clock);
                #1;
                cycles++;
            end
        end
        no_wait = (cycles == 0);
    endtask

    task automatic issue_packet(input int tag, input ooo_inst_pkg::dispatch_t pkt);
        if (!timed_out) begin
            record_op(tag, pkt);
            dispatch_valid     = 1'b1;
            dispatch_data      = pkt;
            credits--;
            last_dispatch_time = $time;
            prev_tag           = tag;
            have_prev          = 1'b1;
            @(posedge clock);
            #1;
            dispatch_valid = 1'b0;
        end
    endtask

    // A source may name only the op dispatched on the cycle before
    task automatic send_op(input int op_sel, input int dep_pct);
        ooo_inst_pkg::dispatch_t pkt;
        bit no_wait;
        bit chained;
        int tag;
        wait_for_credit(no_wait);
        chained = no_wait && have_prev && in_flight[prev_tag] &&
                  ($time - last_dispatch_time == CLK_PERIOD);
        tag = pick_free_tag();
        pkt.op       = ooo_inst_pkg::alu_op_e'((op_sel < 0) ? $urandom_range(7) : op_sel);
        pkt.dest_tag = `TAG_BITS'(tag);
        pkt.a        = make_operand(chained && $urandom_range(99) < dep_pct, prev_tag);
        pkt.b        = make_operand(chained && $urandom_range(99) < dep_pct, prev_tag);
        issue_packet(tag, pkt);
    endtask

    // Consumer reaches its entry in the cycle that its producer broadcasts
    // On an idle DUT the producer broadcasts five cycles after its dispatch
    task automatic send_load_on_broadcast(input bit pend_b);
        ooo_inst_pkg::dispatch_t pkt;
        int p;
        int c;
        if (!timed_out) begin
            p            = pick_free_tag();
            pkt.op       = ooo_inst_pkg::alu_op_e'($urandom_range(7));
            pkt.dest_tag = `TAG_BITS'(p);
            pkt.a        = make_operand(1'b0, 0);
            pkt.b        = make_operand(1'b0, 0);
            issue_packet(p, pkt);
            // Load, issue, two ALU stages, then the result buffer
            repeat (3) begin
                @(posedge clock);
                #1;
            end
            c            = pick_free_tag();
            pkt.op       = ooo_inst_pkg::alu_op_e'($urandom_range(7));
            pkt.dest_tag = `TAG_BITS'(c);
            pkt.a        = make_operand(!pend_b, p);
            pkt.b        = make_operand(pend_b, p);
            issue_packet(c, pkt);
        end
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (!timed_out && (in_flight_count != 0 || credits != `DISPATCH_DEPTH)) begin
            if (cycles == DRAIN_TIMEOUT) begin
                $display("Timed out with %0d operations still in flight", in_flight_count);
                timed_out = 1'b1;
            end else begin
                @(posedge clock);
                #1;
                cycles++;
            end
        end
    endtask

    task automatic start_test();
        test_num++;
        test_start_errors = errors;
    endtask

    task automatic finish_test(input string name);
        if (errors == test_start_errors && !timed_out) begin
            tests_passed++;
            $display("test %0d %s: passed", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed", test_num, name);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        ooo_inst_pkg::dispatch_t pkt;
        bit no_wait;
        int p_tag;
        int c_tag;
        int start_count;

        void'($urandom(32'hfe0d3941));
        reset              = 1'b1;
        dispatch_valid     = 1'b0;
        dispatch_data      = '0;
        credits            = `DISPATCH_DEPTH;
        errors             = 0;
        broadcasts         = 0;
        tests_passed       = 0;
        tests_failed       = 0;
        test_num           = 0;
        timed_out          = 1'b0;
        in_flight_count    = 0;
        have_prev          = 1'b0;
        prev_tag           = 0;
        last_dispatch_time = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            in_flight[t] = 1'b0;
        end
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        // Idle after reset
        start_test();
        repeat (10) begin
            @(negedge clock);
            if (cdb.valid || dispatch_credit) begin
                $display("CHECK FAILED at %0t: output active with no dispatch", $time);
                errors++;
            end
        end
        @(posedge clock);
        #1;
        finish_test("idle after reset");

        start_test();
        for (int i = 0; i < 16; i++) begin
            send_op(i % 8, 0);
        end
        wait_for_drain();
        finish_test("independent operations");

        start_test();
        for (int i = 0; i < 24; i++) begin
            send_op(-1, 70);
        end
        wait_for_drain();
        send_load_on_broadcast(1'b0);
        wait_for_drain();
        send_load_on_broadcast(1'b1);
        wait_for_drain();
        finish_test("dependent chains");

        start_test();
        start_count = broadcasts;
        for (int i = 0; i < 40; i++) begin
            send_op(-1, 30);
        end
        wait_for_drain();
        if (!timed_out && broadcasts - start_count != 40) begin
            $display("CHECK FAILED at %0t: %0d broadcasts for 40 dispatches",
                     $time, broadcasts - start_count);
            errors++;
        end
        finish_test("dispatch burst credits");

        // Chain head waits on a producer that is dispatched last
        start_test();
        start_count = broadcasts;
        p_tag = pick_free_tag();
        reserve_tag(p_tag);
        prev_tag = p_tag;
        for (int i = 0; i < `RS_SIZE - 1; i++) begin
            wait_for_credit(no_wait);
            c_tag        = pick_free_tag();
            pkt.op       = ooo_inst_pkg::alu_op_e'($urandom_range(7));
            pkt.dest_tag = `TAG_BITS'(c_tag);
            pkt.a        = make_operand(1'b1, prev_tag);
            pkt.b        = make_operand(1'b0, 0);
            issue_packet(c_tag, pkt);
        end
        wait_for_credit(no_wait);
        pkt.op       = ooo_inst_pkg::alu_op_e'($urandom_range(7));
        pkt.dest_tag = `TAG_BITS'(p_tag);
        pkt.a        = make_operand(1'b0, 0);
        pkt.b        = make_operand(1'b0, 0);
        issue_packet(p_tag, pkt);
        for (int i = 0; i < 4; i++) begin
            send_op(-1, 0);
        end
        wait_for_drain();
        if (!timed_out && broadcasts - start_count != `RS_SIZE + 4) begin
            $display("CHECK FAILED at %0t: %0d broadcasts, expected %0d",
                     $time, broadcasts - start_count, `RS_SIZE + 4);
            errors++;
        end
        finish_test("back-pressure");

        $display("%0d tests passed, %0d tests failed, %0d check errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+design
design/ooo_inst_pkg.sv
design/ooo_bus_pkg.sv
design/payload_fifo.sv
design/rs_entry.sv
design/rs_scheduler.sv
design/alu_pipe.sv
design/rs_cluster_top.sv
dv/rs_cluster_tb.sv
